// ==== common/vc_pkg.sv ====
package vc_pkg;

    // one row's share of a cache line
    localparam int SLICE_W = 32;
    typedef logic [SLICE_W-1:0] slice_t;

    // entry index inside one bank
    localparam int INDEX_W = 4;
    localparam int DEPTH   = 1 << INDEX_W;
    typedef logic [INDEX_W-1:0] index_t;

    // column select for at most 4 columns in a row
    localparam int BLOCK_W = 2;
    typedef logic [BLOCK_W-1:0] block_t;

    // address layout is {block, index}
    localparam int ADDR_W    = BLOCK_W + INDEX_W;
    localparam int INDEX_LSB = 0;
    localparam int BLOCK_LSB = INDEX_LSB + INDEX_W;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_e;

    function automatic block_t addr_block(addr_t addr);
        return addr[BLOCK_LSB +: BLOCK_W];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[INDEX_LSB +: INDEX_W];
    endfunction

endpackage

// ==== bank_group/bank_sram.sv ====
`timescale 1ns/1ps

module bank_sram (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  logic           rd_en,
    input  vc_pkg::index_t index,
    input  vc_pkg::slice_t wr_slice,
    output vc_pkg::slice_t rd_slice
);

    vc_pkg::slice_t mem [vc_pkg::DEPTH];

    // write lands on the edge where wr_en is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < vc_pkg::DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[index] <= wr_slice;
        end
    end

    // registered read data arrives one cycle after rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_slice <= '0;
        end else if (rd_en) begin
            rd_slice <= mem[index];
        end
    end

endmodule

// ==== bank_group/bank_group.sv ====
`timescale 1ns/1ps

module bank_group #(
    parameter int BLOCK_ID = 0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           west_vld,
    input  vc_pkg::op_e    west_op,
    input  vc_pkg::addr_t  west_addr,
    input  vc_pkg::slice_t west_slice,
    output logic           east_vld,
    output vc_pkg::op_e    east_op,
    output vc_pkg::addr_t  east_addr,
    output vc_pkg::slice_t east_slice
);

    vc_pkg::block_t blk;
    vc_pkg::index_t idx;
    logic           hit;
    logic           wr_en;
    logic           rd_en;
    logic           rd_hit_q;
    vc_pkg::slice_t slice_q;
    vc_pkg::slice_t rd_slice;

    assign blk = vc_pkg::addr_block(west_addr);
    assign idx = vc_pkg::addr_index(west_addr);

    // this tile owns the command when the block field names its column
    assign hit   = west_vld && (blk == vc_pkg::block_t'(BLOCK_ID));
    assign wr_en = hit && (west_op == vc_pkg::op_write);
    assign rd_en = hit && (west_op == vc_pkg::op_read);

    bank_sram sram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .index    (idx),
        .wr_slice (west_slice),
        .rd_slice (rd_slice)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            east_vld <= 1'b0;
            rd_hit_q <= 1'b0;
        end else begin
            east_vld <= west_vld;
            rd_hit_q <= rd_en;
        end
    end

    // hop registers toward the east, one tile per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            east_op   <= vc_pkg::op_read;
            east_addr <= '0;
            slice_q   <= '0;
        end else begin
            east_op   <= west_op;
            east_addr <= west_addr;
            slice_q   <= west_slice;
        end
    end

    // sram output and hop registers line up on the same cycle
    // so a matched read can swap the passing slice for the stored one
    assign east_slice = rd_hit_q ? rd_slice : slice_q;

endmodule

// ==== verilog/bank_row.sv ====
`timescale 1ns/1ps

module bank_row #(
    parameter int COLS = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           west_vld,
    input  vc_pkg::op_e    west_op,
    input  vc_pkg::addr_t  west_addr,
    input  vc_pkg::slice_t west_slice,
    output logic           east_vld,
    output vc_pkg::op_e    east_op,
    output vc_pkg::addr_t  east_addr,
    output vc_pkg::slice_t east_slice
);

    // chain index c is the west side of tile c and index COLS the row's east edge
    logic           vld_w   [COLS+1];
    vc_pkg::op_e    op_w    [COLS+1];
    vc_pkg::addr_t  addr_w  [COLS+1];
    vc_pkg::slice_t slice_w [COLS+1];

    assign vld_w[0]   = west_vld;
    assign op_w[0]    = west_op;
    assign addr_w[0]  = west_addr;
    assign slice_w[0] = west_slice;

    for (genvar c = 0; c < COLS; c++) begin : g_col
        bank_group #(
            .BLOCK_ID (c)
        ) bank_group_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .west_vld   (vld_w[c]),
            .west_op    (op_w[c]),
            .west_addr  (addr_w[c]),
            .west_slice (slice_w[c]),
            .east_vld   (vld_w[c+1]),
            .east_op    (op_w[c+1]),
            .east_addr  (addr_w[c+1]),
            .east_slice (slice_w[c+1])
        );
    end

    // COLS hops later the command leaves the row
    assign east_vld   = vld_w[COLS];
    assign east_op    = op_w[COLS];
    assign east_addr  = addr_w[COLS];
    assign east_slice = slice_w[COLS];

endmodule

// ==== verilog/vec_cache_sram_group.sv ====
`timescale 1ns/1ps

module vec_cache_sram_group #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          west_cmd_vld,
    input  vc_pkg::op_e                   west_cmd_op,
    input  vc_pkg::addr_t                 west_cmd_addr,
    input  logic [ROWS*vc_pkg::SLICE_W-1:0] west_data,
    output logic                          east_cmd_vld,
    output vc_pkg::op_e                   east_cmd_op,
    output vc_pkg::addr_t                 east_cmd_addr,
    output logic [ROWS*vc_pkg::SLICE_W-1:0] east_data
);

    vc_pkg::slice_t west_slice [ROWS];
    logic           row_vld    [ROWS];
    vc_pkg::op_e    row_op     [ROWS];
    vc_pkg::addr_t  row_addr   [ROWS];
    vc_pkg::slice_t east_slice [ROWS];

    // slice r of the line belongs to row r with row 0 at the bottom
    for (genvar r = 0; r < ROWS; r++) begin : g_split
        assign west_slice[r] = west_data[r*vc_pkg::SLICE_W +: vc_pkg::SLICE_W];
    end

    // every row sees the same command and only the data slice differs
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        bank_row #(
            .COLS (COLS)
        ) bank_row_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .west_vld   (west_cmd_vld),
            .west_op    (west_cmd_op),
            .west_addr  (west_cmd_addr),
            .west_slice (west_slice[r]),
            .east_vld   (row_vld[r]),
            .east_op    (row_op[r]),
            .east_addr  (row_addr[r]),
            .east_slice (east_slice[r])
        );
    end

    // rows run in lockstep so row 0 speaks for the command
    assign east_cmd_vld  = row_vld[0];
    assign east_cmd_op   = row_op[0];
    assign east_cmd_addr = row_addr[0];

    for (genvar r = 0; r < ROWS; r++) begin : g_join
        assign east_data[r*vc_pkg::SLICE_W +: vc_pkg::SLICE_W] = east_slice[r];
    end

endmodule

// ==== tests/vec_cache_sram_group_properties.sv ====
`timescale 1ns/1ps

module vec_cache_sram_group_properties #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            west_cmd_vld,
    input logic                            east_cmd_vld,
    input vc_pkg::addr_t                   east_cmd_addr,
    input logic [ROWS*vc_pkg::SLICE_W-1:0] east_data
);

    int violations = 0;

    // fixed pipeline depth of one hop per column
    assert property (@(posedge clk) disable iff (!rst_n)
        east_cmd_vld == $past(west_cmd_vld, COLS))
    else begin
        violations++;
        $error("east_cmd_vld does not follow west_cmd_vld by %0d cycles", COLS);
    end

    assert property (@(posedge clk) !rst_n |-> !east_cmd_vld)
    else begin
        violations++;
        $error("east_cmd_vld high during reset");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        east_cmd_vld |-> !$isunknown(east_data) && !$isunknown(east_cmd_addr))
    else begin
        violations++;
        $error("unknown bits on east_data or east_cmd_addr");
    end

endmodule

// ==== tests/vec_cache_sram_group_tb.sv ====
`timescale 1ns/1ps

module vec_cache_sram_group_tb;

    localparam int ROWS         = 4;
    localparam int COLS         = 4;
    localparam int LINE_W       = ROWS * vc_pkg::SLICE_W;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 20;
    localparam logic [31:0] RNG_SEED = 32'd40;

    logic                clk;
    logic                rst_n;
    logic                west_cmd_vld;
    vc_pkg::op_e         west_cmd_op;
    vc_pkg::addr_t       west_cmd_addr;
    logic [LINE_W-1:0]   west_data;
    logic                east_cmd_vld;
    vc_pkg::op_e         east_cmd_op;
    vc_pkg::addr_t       east_cmd_addr;
    logic [LINE_W-1:0]   east_data;

    // stimulus table with one entry per clock
    logic                tab_vld  [$];
    vc_pkg::op_e         tab_op   [$];
    vc_pkg::addr_t       tab_addr [$];
    int                  tab_seed [$];

    // expected east side as filled by the reference model
    vc_pkg::op_e         exp_op_q    [$];
    vc_pkg::addr_t       exp_addr_q  [$];
    logic [LINE_W-1:0]   exp_data_q  [$];
    int                  exp_cycle_q [$];

    logic [LINE_W-1:0]   ref_mem [64];
    int                  cycle = 0;
    int                  errors = 0;
    int                  outputs = 0;
    logic                table_ready = 1'b0;

    vec_cache_sram_group #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .west_cmd_vld  (west_cmd_vld),
        .west_cmd_op   (west_cmd_op),
        .west_cmd_addr (west_cmd_addr),
        .west_data     (west_data),
        .east_cmd_vld  (east_cmd_vld),
        .east_cmd_op   (east_cmd_op),
        .east_cmd_addr (east_cmd_addr),
        .east_data     (east_data)
    );

    bind vec_cache_sram_group vec_cache_sram_group_properties #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) props_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .west_cmd_vld  (west_cmd_vld),
        .east_cmd_vld  (east_cmd_vld),
        .east_cmd_addr (east_cmd_addr),
        .east_data     (east_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // seeds spaced by ROWS steps never share a slice value
    function automatic logic [LINE_W-1:0] make_line(int seed);
        logic [31:0]       state;
        logic [LINE_W-1:0] line;
        state = RNG_SEED;
        for (int k = 0; k < seed * ROWS; k++) begin
            state = xorshift32(state);
        end
        for (int r = 0; r < ROWS; r++) begin
            state = xorshift32(state);
            line[r*vc_pkg::SLICE_W +: vc_pkg::SLICE_W] = state;
        end
        return line;
    endfunction

    task automatic add_cmd(logic vld, vc_pkg::op_e op, vc_pkg::addr_t addr, int seed);
        tab_vld.push_back(vld);
        tab_op.push_back(op);
        tab_addr.push_back(addr);
        tab_seed.push_back(seed);
    endtask

    task automatic build_table();
        // idle after reset and then reads of addresses never written
        add_cmd(1'b0, vc_pkg::op_read,  6'h00, 0);
        add_cmd(1'b0, vc_pkg::op_read,  6'h00, 0);
        add_cmd(1'b1, vc_pkg::op_read,  6'h05, 1);
        add_cmd(1'b1, vc_pkg::op_read,  6'h3f, 2);
        // write, gap, read back
        add_cmd(1'b1, vc_pkg::op_write, 6'h12, 3);
        add_cmd(1'b0, vc_pkg::op_read,  6'h00, 0);
        add_cmd(1'b0, vc_pkg::op_read,  6'h00, 0);
        add_cmd(1'b1, vc_pkg::op_read,  6'h12, 4);
        // overwrite then read on the very next cycle
        add_cmd(1'b1, vc_pkg::op_write, 6'h12, 5);
        add_cmd(1'b1, vc_pkg::op_read,  6'h12, 6);
        // same index in every block
        add_cmd(1'b1, vc_pkg::op_write, 6'h07, 7);
        add_cmd(1'b1, vc_pkg::op_write, 6'h17, 8);
        add_cmd(1'b1, vc_pkg::op_write, 6'h27, 9);
        add_cmd(1'b1, vc_pkg::op_write, 6'h37, 10);
        add_cmd(1'b1, vc_pkg::op_read,  6'h37, 11);
        add_cmd(1'b1, vc_pkg::op_read,  6'h27, 12);
        add_cmd(1'b1, vc_pkg::op_read,  6'h17, 13);
        add_cmd(1'b1, vc_pkg::op_read,  6'h07, 14);
        // mixed back-to-back traffic
        add_cmd(1'b1, vc_pkg::op_write, 6'h2a, 15);
        add_cmd(1'b1, vc_pkg::op_read,  6'h07, 16);
        add_cmd(1'b1, vc_pkg::op_write, 6'h3c, 17);
        add_cmd(1'b1, vc_pkg::op_read,  6'h2a, 18);
        add_cmd(1'b0, vc_pkg::op_read,  6'h00, 0);
        add_cmd(1'b1, vc_pkg::op_read,  6'h3c, 19);
        add_cmd(1'b1, vc_pkg::op_read,  6'h12, 20);
    endtask

    task automatic model_command(int k, int due);
        logic [LINE_W-1:0] line;
        line = make_line(tab_seed[k]);
        if (tab_op[k] == vc_pkg::op_write) begin
            ref_mem[tab_addr[k]] = line;
            exp_data_q.push_back(line);
        end else begin
            exp_data_q.push_back(ref_mem[tab_addr[k]]);
        end
        exp_op_q.push_back(tab_op[k]);
        exp_addr_q.push_back(tab_addr[k]);
        exp_cycle_q.push_back(due);
    endtask

    task automatic check_output();
        vc_pkg::op_e       exp_op;
        vc_pkg::addr_t     exp_addr;
        logic [LINE_W-1:0] exp_data;
        int                exp_cycle;
        assert (exp_op_q.size() != 0) else begin
            $display("[ERROR] %0t: east_cmd_vld high with no command in flight", $time);
            errors++;
        end
        if (exp_op_q.size() != 0) begin
            exp_op    = exp_op_q.pop_front();
            exp_addr  = exp_addr_q.pop_front();
            exp_data  = exp_data_q.pop_front();
            exp_cycle = exp_cycle_q.pop_front();
            outputs++;
            assert (cycle == exp_cycle) else begin
                $display("[ERROR] %0t: output on cycle %0d, expected cycle %0d",
                         $time, cycle, exp_cycle);
                errors++;
            end
            assert (east_cmd_op == exp_op) else begin
                $display("[ERROR] %0t: op %0d, expected %0d", $time, east_cmd_op, exp_op);
                errors++;
            end
            assert (east_cmd_addr == exp_addr) else begin
                $display("[ERROR] %0t: addr %h, expected %h", $time, east_cmd_addr, exp_addr);
                errors++;
            end
            for (int r = 0; r < ROWS; r++) begin
                assert (east_data[r*vc_pkg::SLICE_W +: vc_pkg::SLICE_W] ==
                        exp_data[r*vc_pkg::SLICE_W +: vc_pkg::SLICE_W]) else begin
                    $display("[ERROR] %0t: addr %h row %0d slice %h, expected %h", $time,
                             exp_addr, r, east_data[r*vc_pkg::SLICE_W +: vc_pkg::SLICE_W],
                             exp_data[r*vc_pkg::SLICE_W +: vc_pkg::SLICE_W]);
                    errors++;
                end
            end
        end
    endtask

    // sample away from the driving edge
    always @(negedge clk) begin
        if (rst_n && east_cmd_vld) begin
            check_output();
        end
    end

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (tab_vld.size() + COLS + RESET_CYCLES + MARGIN) * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int leftovers;
        int violations;
        rst_n         = 1'b0;
        west_cmd_vld  = 1'b0;
        west_cmd_op   = vc_pkg::op_read;
        west_cmd_addr = '0;
        west_data     = '0;
        for (int a = 0; a < 64; a++) begin
            ref_mem[a] = '0;
        end
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < tab_vld.size(); k++) begin
            @(posedge clk);
            west_cmd_vld  <= tab_vld[k];
            west_cmd_op   <= tab_op[k];
            west_cmd_addr <= tab_addr[k];
            west_data     <= make_line(tab_seed[k]);
            // due at the negedge that follows COLS more edges after the capture
            if (tab_vld[k]) begin
                model_command(k, cycle + 1 + COLS);
            end
        end
        @(posedge clk);
        west_cmd_vld <= 1'b0;
        repeat (COLS + 2) @(posedge clk);
        @(negedge clk);

        leftovers = exp_op_q.size();
        assert (leftovers == 0) else begin
            $display("%0d expected outputs never left the east side", leftovers);
        end
        violations = dut_i.props_i.violations;
        $display("outputs checked %0d, errors %0d, property failures %0d, leftovers %0d",
                 outputs, errors, violations, leftovers);
        if (errors == 0 && violations == 0 && leftovers == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vec_cache_sram_group.f ====
common/vc_pkg.sv
bank_group/bank_sram.sv
bank_group/bank_group.sv
verilog/bank_row.sv
verilog/vec_cache_sram_group.sv
tests/vec_cache_sram_group_properties.sv
tests/vec_cache_sram_group_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module vec_cache_sram_group_tb \
    -f vec_cache_sram_group.f \
    -o vec_cache_sram_group_tb \
    && ./obj_dir/vec_cache_sram_group_tb +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation did not complete"

[ -f sim.log ] && cat sim.log
grep -qx "Testbench passed" sim.log 2>/dev/null && exit 0 || exit 1
